// ==== source/cmd_pkg.sv ====
/*
 * Command encoder shared definitions
 * Bus and memory sizes, register map, sync pattern and sequencer states
 */
`default_nettype none

package cmd_pkg;

    localparam int bus_addr_w = 16;
    localparam int mem_addr_w = 10;

    // Command memory depth, also read back over the bus
    localparam logic [15:0] mem_size = 16'(2 ** mem_addr_w);

    // Memory bytes start right after the register block
    localparam logic [bus_addr_w-1:0] reg_space = 16;

    localparam logic [7:0] version = 8'd1;

    localparam logic [bus_addr_w-1:0] addr_ctrl     = 0;
    localparam logic [bus_addr_w-1:0] addr_start    = 1;
    localparam logic [bus_addr_w-1:0] addr_size_lo  = 3;
    localparam logic [bus_addr_w-1:0] addr_size_hi  = 4;
    localparam logic [bus_addr_w-1:0] addr_rep_lo   = 5;
    localparam logic [bus_addr_w-1:0] addr_rep_hi   = 6;
    localparam logic [bus_addr_w-1:0] addr_msize_lo = 7;
    localparam logic [bus_addr_w-1:0] addr_msize_hi = 8;

    // High byte goes out first
    localparam logic [15:0] sync_word = 16'h817E;

    typedef enum logic [1:0] {
        st_init,
        st_sync,
        st_data
    } seq_state_t;

endpackage

`default_nettype wire

// ==== source/cmd_ctrl_if.sv ====
/*
 * Control and status link between register bank and sequencer
 */
`timescale 1ns/10ps
`default_nettype none

interface cmd_ctrl_if;

    // Strobes and settings from the register bank
    logic        start;
    logic        soft_rst;
    logic [15:0] cmd_size;
    logic [15:0] repeat_count;

    // Status levels from the sequencer
    logic        done;
    logic        syncing;

    modport regs (output start, soft_rst, cmd_size, repeat_count, input done, syncing);

    modport seq (input start, soft_rst, cmd_size, repeat_count, output done, syncing);

endinterface

`default_nettype wire

// ==== source/cmd_regs.sv ====
/*
 * Command encoder register bank
 * Decodes bus writes, holds size and repeat settings, muxes readback
 */
`timescale 1ns/10ps
`default_nettype none

module cmd_regs (
    input  logic                        BUS_CLK,
    input  logic                        RST,
    input  logic [cmd_pkg::bus_addr_w-1:0] bus_add,
    input  logic [7:0]                  bus_data_in,
    input  logic                        bus_rd,
    input  logic                        bus_wr,
    input  logic [7:0]                  bus_mem_rdata,
    output logic [7:0]                  bus_data_out,
    output logic                        bus_mem_en,
    output logic                        bus_mem_we,
    output logic [cmd_pkg::mem_addr_w-1:0] bus_mem_addr,
    output logic [7:0]                  bus_mem_wdata,
    cmd_ctrl_if.regs                    ctrl
);

    import cmd_pkg::*;

    logic [15:0]           size_q;
    logic [15:0]           rep_q;
    logic [7:0]            rd_data_q;
    logic [bus_addr_w-1:0] prev_add;
    logic                  wr_ctrl;
    logic                  in_mem;

    assign wr_ctrl = bus_wr && (bus_add == addr_ctrl);
    assign in_mem  = (bus_add >= reg_space) && (bus_add < reg_space + mem_size);

    assign ctrl.soft_rst     = wr_ctrl;
    assign ctrl.start        = bus_wr && (bus_add == addr_start);
    assign ctrl.cmd_size     = size_q;
    assign ctrl.repeat_count = rep_q;

    // Memory side of the bus
    assign bus_mem_en    = (bus_wr || bus_rd) && in_mem;
    assign bus_mem_we    = bus_wr;
    assign bus_mem_addr  = mem_addr_w'(bus_add - reg_space);
    assign bus_mem_wdata = bus_data_in;

    always_ff @(posedge BUS_CLK) begin
        if (RST || wr_ctrl) begin
            size_q <= 16'd0;
            rep_q  <= 16'd1;
        end else if (bus_wr) begin
            case (bus_add)
                addr_size_lo: size_q[7:0]  <= bus_data_in;
                addr_size_hi: size_q[15:8] <= bus_data_in;
                addr_rep_lo:  rep_q[7:0]   <= bus_data_in;
                addr_rep_hi:  rep_q[15:8]  <= bus_data_in;
                default: ;
            endcase
        end
    end

    // Register readback, zero when no read
    always_ff @(posedge BUS_CLK) begin
        if (RST || !bus_rd) begin
            rd_data_q <= 8'h00;
            prev_add  <= '0;
        end else begin
            prev_add <= bus_add;
            case (bus_add)
                addr_ctrl:     rd_data_q <= version;
                addr_start:    rd_data_q <= {6'b0, ctrl.syncing, ctrl.done};
                addr_size_lo:  rd_data_q <= size_q[7:0];
                addr_size_hi:  rd_data_q <= size_q[15:8];
                addr_rep_lo:   rd_data_q <= rep_q[7:0];
                addr_rep_hi:   rd_data_q <= rep_q[15:8];
                addr_msize_lo: rd_data_q <= mem_size[7:0];
                addr_msize_hi: rd_data_q <= mem_size[15:8];
                default:       rd_data_q <= 8'h00;
            endcase
        end
    end

    always_comb begin
        if (prev_add < reg_space)
            bus_data_out = rd_data_q;
        else if (prev_add < reg_space + mem_size)
            bus_data_out = bus_mem_rdata;
        else
            bus_data_out = 8'h00;
    end

    // Host never reads and writes in one cycle
    a_rd_wr_excl: assert property (@(posedge BUS_CLK) disable iff (RST) !(bus_rd && bus_wr))
        else $error("bus_rd and bus_wr high together");

endmodule

`default_nettype wire

// ==== source/cmd_mem.sv ====
/*
 * Command byte memory
 * Bus read/write port and a read-only port for the sequencer
 */
`timescale 1ns/10ps
`default_nettype none

module cmd_mem (
    input  logic                           BUS_CLK,
    input  logic                           bus_mem_en,
    input  logic                           bus_mem_we,
    input  logic [cmd_pkg::mem_addr_w-1:0] bus_mem_addr,
    input  logic [7:0]                     bus_mem_wdata,
    input  logic [cmd_pkg::mem_addr_w-1:0] seq_addr,
    output logic [7:0]                     bus_mem_rdata,
    output logic [7:0]                     seq_rdata
);

    import cmd_pkg::*;

    logic [7:0] mem [mem_size];

    // Read returns the old contents on a write
    always_ff @(posedge BUS_CLK) begin
        if (bus_mem_en) begin
            if (bus_mem_we)
                mem[bus_mem_addr] <= bus_mem_wdata;
            bus_mem_rdata <= mem[bus_mem_addr];
        end
    end

    always_ff @(posedge BUS_CLK) begin
        seq_rdata <= mem[seq_addr];
    end

endmodule

`default_nettype wire

// ==== source/cmd_sequencer.sv ====
/*
 * Command sequencer
 * Chooses sync or stored bytes and counts addresses and repetitions
 */
`timescale 1ns/10ps
`default_nettype none

module cmd_sequencer (
    input  logic                           BUS_CLK,
    input  logic                           RST,
    input  logic [7:0]                     seq_rdata,
    input  logic                           next_byte,
    output logic [cmd_pkg::mem_addr_w-1:0] seq_addr,
    output logic [7:0]                     tx_byte,
    output logic                           shift_en,
    cmd_ctrl_if.seq                        ctrl
);

    import cmd_pkg::*;

    seq_state_t  state;
    logic        seq_rst;
    logic        pending;
    logic        sync_lo;
    logic        done_q;
    logic [15:0] rep_cnt;
    logic [15:0] addr_ext;
    logic        last_byte;
    logic        last_rep;

    assign seq_rst   = RST || ctrl.soft_rst;
    assign addr_ext  = 16'(seq_addr);
    assign last_byte = (addr_ext == ctrl.cmd_size - 16'd1);
    assign last_rep  = (rep_cnt == ctrl.repeat_count - 16'd1);

    assign shift_en     = (state != st_init);
    assign ctrl.syncing = (state == st_sync);
    assign ctrl.done    = done_q;

    always_comb begin
        case (state)
            st_sync: tx_byte = sync_lo ? sync_word[7:0] : sync_word[15:8];
            st_data: tx_byte = seq_rdata;
            default: tx_byte = 8'h00;
        endcase
    end

    always_ff @(posedge BUS_CLK) begin
        if (seq_rst) begin
            state    <= st_init;
            pending  <= 1'b0;
            sync_lo  <= 1'b0;
            seq_addr <= '0;
            rep_cnt  <= 16'd0;
            done_q   <= 1'b1;
        end else begin
            // Starts while a frame runs are dropped
            if (ctrl.start && state != st_data && ctrl.cmd_size != 16'd0 &&
                    ctrl.repeat_count != 16'd0) begin
                pending <= 1'b1;
                done_q  <= 1'b0;
            end
            case (state)
                st_init: begin
                    if (ctrl.start)
                        state <= st_sync;
                end
                st_sync: begin
                    if (next_byte && pending) begin
                        state   <= st_data;
                        pending <= 1'b0;
                    end else if (next_byte) begin
                        sync_lo <= ~sync_lo;
                    end
                end
                st_data: begin
                    if (next_byte && last_byte) begin
                        seq_addr <= '0;
                        if (last_rep) begin
                            state   <= st_sync;
                            sync_lo <= 1'b0;
                            rep_cnt <= 16'd0;
                            done_q  <= 1'b1;
                        end else begin
                            rep_cnt <= rep_cnt + 16'd1;
                        end
                    end else if (next_byte) begin
                        seq_addr <= seq_addr + 1'b1;
                    end
                end
                default: state <= st_init;
            endcase
        end
    end

    a_no_init_return: assert property (@(posedge BUS_CLK)
            (state != st_init && !seq_rst) |=> state != st_init)
        else $error("sequencer fell back to st_init without reset");

    a_addr_range: assert property (@(posedge BUS_CLK) disable iff (seq_rst)
            state == st_data |-> addr_ext < ctrl.cmd_size)
        else $error("seq_addr %0d beyond cmd_size %0d", addr_ext, ctrl.cmd_size);

endmodule

`default_nettype wire

// ==== source/cmd_serializer.sv ====
/*
 * Command serializer
 * Shifts bytes out LSB first, one bit per clock
 */
`timescale 1ns/10ps
`default_nettype none

module cmd_serializer (
    input  logic       BUS_CLK,
    input  logic       RST,
    input  logic       shift_en,
    input  logic [7:0] tx_byte,
    output logic       next_byte,
    output logic       serial_out
);

    logic [7:0] shift_q;
    logic [2:0] bit_cnt;

    // Count parks at 7 so the first enabled cycle loads a byte
    assign next_byte  = shift_en && (bit_cnt == 3'd7);
    assign serial_out = shift_en && shift_q[0];

    always_ff @(posedge BUS_CLK) begin
        if (RST || !shift_en) begin
            bit_cnt <= 3'd7;
            shift_q <= 8'h00;
        end else begin
            bit_cnt <= bit_cnt + 3'd1;
            if (next_byte)
                shift_q <= tx_byte;
            else
                shift_q <= {1'b0, shift_q[7:1]};
        end
    end

    a_byte_period: assert property (@(posedge BUS_CLK) disable iff (RST)
            next_byte ##1 shift_en [*8] |-> next_byte)
        else $error("next_byte missing after 8 cycles");

    a_no_early_byte: assert property (@(posedge BUS_CLK) disable iff (RST)
            next_byte |=> !next_byte [*7])
        else $error("next_byte came early");

endmodule

`default_nettype wire

// ==== source/cmd_encoder_top.sv ====
/*
 * Serial command encoder top level
 * Register bus in, LSB-first command stream out
 */
`timescale 1ns/10ps
`default_nettype none

module cmd_encoder_top (
    input  logic                           BUS_CLK,
    input  logic                           RST,
    input  logic [cmd_pkg::bus_addr_w-1:0] bus_add,
    input  logic [7:0]                     bus_data_in,
    input  logic                           bus_rd,
    input  logic                           bus_wr,
    output logic [7:0]                     bus_data_out,
    output logic                           cmd_serial_out
);

    import cmd_pkg::*;

    logic                  bus_mem_en;
    logic                  bus_mem_we;
    logic [mem_addr_w-1:0] bus_mem_addr;
    logic [7:0]            bus_mem_wdata;
    logic [7:0]            bus_mem_rdata;
    logic [mem_addr_w-1:0] seq_addr;
    logic [7:0]            seq_rdata;
    logic [7:0]            tx_byte;
    logic                  shift_en;
    logic                  next_byte;

    cmd_ctrl_if ctrl_if ();

    cmd_regs regs_i (
        .BUS_CLK       (BUS_CLK),
        .RST           (RST),
        .bus_add       (bus_add),
        .bus_data_in   (bus_data_in),
        .bus_rd        (bus_rd),
        .bus_wr        (bus_wr),
        .bus_mem_rdata (bus_mem_rdata),
        .bus_data_out  (bus_data_out),
        .bus_mem_en    (bus_mem_en),
        .bus_mem_we    (bus_mem_we),
        .bus_mem_addr  (bus_mem_addr),
        .bus_mem_wdata (bus_mem_wdata),
        .ctrl          (ctrl_if.regs)
    );

    cmd_mem mem_i (
        .BUS_CLK       (BUS_CLK),
        .bus_mem_en    (bus_mem_en),
        .bus_mem_we    (bus_mem_we),
        .bus_mem_addr  (bus_mem_addr),
        .bus_mem_wdata (bus_mem_wdata),
        .seq_addr      (seq_addr),
        .bus_mem_rdata (bus_mem_rdata),
        .seq_rdata     (seq_rdata)
    );

    cmd_sequencer seq_i (
        .BUS_CLK   (BUS_CLK),
        .RST       (RST),
        .seq_rdata (seq_rdata),
        .next_byte (next_byte),
        .seq_addr  (seq_addr),
        .tx_byte   (tx_byte),
        .shift_en  (shift_en),
        .ctrl      (ctrl_if.seq)
    );

    cmd_serializer ser_i (
        .BUS_CLK    (BUS_CLK),
        .RST        (RST),
        .shift_en   (shift_en),
        .tx_byte    (tx_byte),
        .next_byte  (next_byte),
        .serial_out (cmd_serial_out)
    );

endmodule

`default_nettype wire

// ==== bench/cmd_encoder_tb.sv ====
/*
 * Command encoder testbench
 * Bus register and memory access, serial stream decode and checking
 */
`timescale 1ns/10ps
`default_nettype none

module cmd_encoder_tb;

    import cmd_pkg::*;

    logic        BUS_CLK;
    logic        RST;
    logic [15:0] bus_add;
    logic [7:0]  bus_data_in;
    logic        bus_rd;
    logic        bus_wr;
    logic [7:0]  bus_data_out;
    logic        cmd_serial_out;

    // Expected bus readback, one cycle behind bus_rd
    logic [7:0]  rd_exp, rd_mask, out_exp, out_mask, last_rd;

    // Stream decoder and frame model
    logic        stream_on, frame_req, locked, sync_hi, in_frame, byte_valid;
    logic [15:0] window;
    logic [2:0]  bit_pos;
    logic [7:0]  rx_byte, exp_byte;
    logic [7:0]  frame_q[$];
    logic [7:0]  mem_model [64];
    logic [31:0] rng;
    int          frame_n, frame_r;
    int          sync_count = 0;
    int          byte_errors = 0;
    int          bus_errors = 0;
    int          idle_errors = 0;
    int          timeouts = 0;

    cmd_encoder_top cmd_encoder_top_i (
        .BUS_CLK        (BUS_CLK),
        .RST            (RST),
        .bus_add        (bus_add),
        .bus_data_in    (bus_data_in),
        .bus_rd         (bus_rd),
        .bus_wr         (bus_wr),
        .bus_data_out   (bus_data_out),
        .cmd_serial_out (cmd_serial_out)
    );

    initial begin
        BUS_CLK = 1'b0;
        forever #50 BUS_CLK = ~BUS_CLK;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge BUS_CLK) begin
        out_exp  <= bus_rd ? (rd_exp & rd_mask) : 8'h00;
        out_mask <= bus_rd ? rd_mask : 8'hFF;
    end

    always @(posedge BUS_CLK) begin : decode
        logic [15:0] win;
        logic [7:0]  sync_exp;
        logic [7:0]  nxt;
        int          rep;
        int          idx;
        win = {cmd_serial_out, window[15:1]};
        sync_exp = sync_hi ? sync_word[15:8] : sync_word[7:0];
        byte_valid <= 1'b0;
        if (frame_req) begin
            for (rep = 0; rep < frame_r; rep++)
                for (idx = 0; idx < frame_n; idx++)
                    frame_q.push_back(mem_model[idx[5:0]]);
        end
        if (RST || !stream_on) begin
            window   <= 16'h0000;
            locked   <= 1'b0;
            bit_pos  <= 3'd0;
            sync_hi  <= 1'b1;
            in_frame <= 1'b0;
        end else begin
            window <= win;
            if (!locked) begin
                // High byte arrived first, so it sits in the low half
                if (win == {sync_word[7:0], sync_word[15:8]}) begin
                    locked  <= 1'b1;
                    bit_pos <= 3'd0;
                    sync_hi <= 1'b1;
                end
            end else begin
                bit_pos <= bit_pos + 3'd1;
                if (bit_pos == 3'd7) begin
                    byte_valid <= 1'b1;
                    rx_byte    <= win[15:8];
                    if (in_frame || (frame_q.size() != 0 && win[15:8] != sync_exp)) begin
                        nxt = frame_q.pop_front();
                        exp_byte <= nxt;
                        in_frame <= (frame_q.size() != 0);
                        // Sync restarts with the high byte
                        if (frame_q.size() == 0)
                            sync_hi <= 1'b1;
                    end else begin
                        exp_byte   <= sync_exp;
                        sync_hi    <= !sync_hi;
                        sync_count <= sync_count + 1;
                    end
                end
            end
        end
    end

    a_stream_byte: assert property (@(posedge BUS_CLK) disable iff (RST)
            byte_valid |-> rx_byte == exp_byte)
        else begin
            byte_errors++;
            $display("** Error %0t ns: cmd_serial_out byte %h, expected %h",
                $time, $sampled(rx_byte), $sampled(exp_byte));
        end

    a_bus_readback: assert property (@(posedge BUS_CLK) disable iff (RST)
            (bus_data_out & out_mask) == out_exp)
        else begin
            bus_errors++;
            $display("** Error %0t ns: bus_data_out %h, expected %h", $time,
                $sampled(bus_data_out) & $sampled(out_mask), $sampled(out_exp));
        end

    a_serial_idle: assert property (@(posedge BUS_CLK) disable iff (RST)
            !stream_on |-> !cmd_serial_out)
        else begin
            idle_errors++;
            $display("** Error %0t ns: cmd_serial_out %b, expected 0", $time,
                $sampled(cmd_serial_out));
        end

    task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
        @(posedge BUS_CLK);
        bus_add     <= addr;
        bus_data_in <= data;
        bus_wr      <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr <= 1'b0;
        if (addr == addr_ctrl)
            stream_on <= 1'b0;
        else if (addr == addr_start)
            stream_on <= 1'b1;
    endtask

    // Mask 00 reads without checking
    task automatic bus_read(input logic [15:0] addr, input logic [7:0] exp_val,
            input logic [7:0] mask);
        @(posedge BUS_CLK);
        bus_add <= addr;
        bus_rd  <= 1'b1;
        rd_exp  <= exp_val;
        rd_mask <= mask;
        @(posedge BUS_CLK);
        bus_rd <= 1'b0;
        @(negedge BUS_CLK);
        last_rd = bus_data_out;
    endtask

    task automatic wait_sync_bytes(input int n);
        int target;
        int cnt;
        target = sync_count + n;
        cnt = 0;
        while (sync_count < target && cnt < 2000) begin
            @(negedge BUS_CLK);
            cnt++;
        end
        if (sync_count < target) begin
            timeouts++;
            $display("Timeout at %0t ns: sync bytes did not arrive", $time);
        end
    endtask

    task automatic wait_done();
        int cnt;
        cnt = 0;
        bus_read(addr_start, 8'h00, 8'h00);
        while (!last_rd[0] && cnt < 500) begin
            bus_read(addr_start, 8'h00, 8'h00);
            cnt++;
        end
        if (!last_rd[0]) begin
            timeouts++;
            $display("Timeout at %0t ns: done bit never came back", $time);
        end
    endtask

    task automatic wait_frame_end();
        int cnt;
        cnt = 0;
        while (frame_q.size() != 0 && cnt < 2000) begin
            @(negedge BUS_CLK);
            cnt++;
        end
        if (frame_q.size() != 0) begin
            timeouts++;
            $display("Timeout at %0t ns: frame bytes missing from stream", $time);
        end
        wait_sync_bytes(4);
    endtask

    task automatic run_frame(input int n, input int r);
        bus_write(addr_size_lo, 8'(n));
        bus_write(addr_size_hi, 8'h00);
        bus_write(addr_rep_lo, 8'(r));
        bus_write(addr_rep_hi, 8'h00);
        bus_read(addr_start, 8'h03, 8'hFF);
        frame_n = n;
        frame_r = r;
        @(posedge BUS_CLK);
        frame_req <= 1'b1;
        @(posedge BUS_CLK);
        frame_req <= 1'b0;
        bus_write(addr_start, 8'h00);
        // Only done is fixed here, syncing depends on the byte phase
        bus_read(addr_start, 8'h00, 8'h01);
        wait_done();
        wait_frame_end();
        bus_read(addr_start, 8'h03, 8'hFF);
    endtask

    initial begin
        int         i;
        logic [7:0] b;
        RST         = 1'b1;
        bus_add     = 16'h0000;
        bus_data_in = 8'h00;
        bus_rd      = 1'b0;
        bus_wr      = 1'b0;
        rd_exp      = 8'h00;
        rd_mask     = 8'h00;
        stream_on   = 1'b0;
        frame_req   = 1'b0;
        frame_n     = 0;
        frame_r     = 0;
        rng         = 32'hebd8_1c88;
        repeat (4) @(posedge BUS_CLK);
        RST <= 1'b0;

        bus_read(addr_ctrl, version, 8'hFF);
        bus_read(addr_start, 8'h01, 8'hFF);
        bus_read(addr_rep_lo, 8'h01, 8'hFF);
        bus_read(addr_rep_hi, 8'h00, 8'hFF);
        bus_read(addr_msize_lo, mem_size[7:0], 8'hFF);
        bus_read(addr_msize_hi, mem_size[15:8], 8'hFF);

        bus_write(addr_size_lo, 8'hA5);
        bus_write(addr_size_hi, 8'h3C);
        bus_write(addr_rep_lo, 8'h5A);
        bus_write(addr_rep_hi, 8'hC3);
        bus_read(addr_size_lo, 8'hA5, 8'hFF);
        bus_read(addr_size_hi, 8'h3C, 8'hFF);
        bus_read(addr_rep_lo, 8'h5A, 8'hFF);
        bus_read(addr_rep_hi, 8'hC3, 8'hFF);

        for (i = 0; i < 64; i++) begin
            rng = lcg_next(rng);
            b = rng[23:16];
            // First frame byte kept apart from both sync bytes
            if (i == 0 && (b == 8'h81 || b == 8'h7E))
                b = b ^ 8'h10;
            mem_model[i[5:0]] = b;
            bus_write(reg_space + 16'(i), b);
        end
        for (i = 0; i < 64; i++)
            bus_read(reg_space + 16'(i), mem_model[i[5:0]], 8'hFF);

        // Empty command, stream stays on sync
        bus_write(addr_size_lo, 8'h00);
        bus_write(addr_size_hi, 8'h00);
        bus_write(addr_start, 8'h00);
        wait_sync_bytes(8);
        bus_read(addr_start, 8'h03, 8'hFF);

        run_frame(5, 3);
        run_frame(1, 2);

        // Soft reset while a frame is still pending
        bus_write(addr_size_lo, 8'h07);
        bus_write(addr_rep_lo, 8'h04);
        bus_write(addr_start, 8'h00);
        bus_read(addr_start, 8'h00, 8'h01);
        bus_write(addr_ctrl, 8'h00);
        bus_read(addr_size_lo, 8'h00, 8'hFF);
        bus_read(addr_size_hi, 8'h00, 8'hFF);
        bus_read(addr_rep_lo, 8'h01, 8'hFF);
        bus_read(addr_rep_hi, 8'h00, 8'hFF);
        bus_read(addr_start, 8'h01, 8'hFF);
        bus_write(addr_start, 8'h00);
        wait_sync_bytes(6);

        repeat (4) @(posedge BUS_CLK);
        $display("Errors: stream %0d, bus %0d, idle %0d, timeouts %0d",
            byte_errors, bus_errors, idle_errors, timeouts);
        if (byte_errors + bus_errors + idle_errors + timeouts == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
source/cmd_pkg.sv
source/cmd_ctrl_if.sv
source/cmd_regs.sv
source/cmd_mem.sv
source/cmd_sequencer.sv
source/cmd_serializer.sv
source/cmd_encoder_top.sv
bench/cmd_encoder_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FILELIST  ?= vlog.f
TB_TOP    ?= cmd_encoder_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert --timescale 1ns/10ps
PASS_MSG  ?= Everything OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)

# The run passes only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)
